//--- source/pong_pkg.sv
`default_nettype none

package pong_pkg;

    // --------------------
    // Screen geometry
    // --------------------
    localparam int h_visible      = 640;
    localparam int v_visible      = 480;
    localparam int coord_w        = 10;

    localparam int paddle_w       = 8;
    localparam int paddle_h       = 64;
    localparam int paddle_x_left  = 32;
    localparam int paddle_x_right = 600;    // h_visible - 32 - paddle_w
    localparam int ball_size      = 8;

    // --------------------
    // Game rules
    // --------------------
    localparam int speed_start    = 2;
    localparam int speed_max      = 5;
    localparam int hits_per_step  = 4;      // Paddle hits per speed step
    localparam int win_score      = 5;
    localparam int player_speed   = 4;
    localparam int auto_speed     = 2;      // Right paddle runs at half speed
    localparam int auto_deadband  = 16;

    localparam int paddle_y_home  = 208;    // (480 - 64) / 2
    localparam int ball_x_home    = 316;
    localparam int ball_y_home    = 236;

    typedef logic [coord_w-1:0] coord_t;
    typedef logic [3:0]         score_t;
    typedef logic [2:0]         speed_t;

    typedef struct packed {
        coord_t x;
        coord_t y;
        logic   dir_right;
        logic   dir_down;
    } ball_t;

    typedef struct packed {
        logic up;
        logic down;
    } move_t;

    typedef struct packed {
        coord_t x;
        coord_t y;
        logic   display_en;
    } pixel_t;

    typedef struct packed {
        logic [3:0] r;
        logic [3:0] g;
        logic [3:0] b;
    } rgb_t;

    typedef enum logic {
        gs_play,
        gs_over
    } game_state_e;

endpackage

`default_nettype wire

//--- source/paddle_command.sv
`timescale 1ns/1ns
`default_nettype none

module paddle_command
    import pong_pkg::*;
#(
    parameter int num_paddles = 2
) (
    input  wire logic                          frame_tick,
    input  wire logic                          btn_u,
    input  wire logic                          btn_d,
    input  game_state_e                        state,
    input  ball_t                              ball,
    input  coord_t                             right_y,
    output move_t       [num_paddles-1:0]      move
);

    logic              active;
    logic [coord_w:0]  ball_c;     // One spare bit so the sums never wrap
    logic [coord_w:0]  pad_c;

    // Moves only count on a game tick
    assign active = frame_tick && (state == gs_play);

    assign ball_c = {1'b0, ball.y} + (coord_w+1)'(ball_size / 2);
    assign pad_c  = {1'b0, right_y} + (coord_w+1)'(paddle_h / 2);

    always_comb begin
        // Player paddle follows the buttons as pressed
        move[0].up   = active && btn_u;
        move[0].down = active && btn_d;

        // Automatic paddle chases the ball centre outside the deadband
        move[1].down = active && (ball_c > pad_c + (coord_w+1)'(auto_deadband));
        move[1].up   = active && (ball_c + (coord_w+1)'(auto_deadband) < pad_c);
    end

endmodule

`default_nettype wire

//--- source/paddle_mover.sv
`timescale 1ns/1ns
`default_nettype none

module paddle_mover
    import pong_pkg::*;
#(
    parameter int step = 4
) (
    input  wire logic clk_pix,
    input  wire logic reset,
    input  wire logic restart,
    input  move_t     move,
    output coord_t    paddle_y
);

    localparam coord_t y_max  = coord_t'(v_visible - paddle_h);
    localparam coord_t y_home = coord_t'(paddle_y_home);

    always_ff @(posedge clk_pix) begin
        if (reset || restart) begin
            paddle_y <= y_home;                     // Recentre for a new game
        end else if (move.down) begin
            // Down wins when both are pressed
            if (paddle_y <= y_max - coord_t'(step)) begin
                paddle_y <= paddle_y + coord_t'(step);
            end else begin
                paddle_y <= y_max;                  // Clamp at bottom edge
            end
        end else if (move.up) begin
            if (paddle_y >= coord_t'(step)) begin
                paddle_y <= paddle_y - coord_t'(step);
            end else begin
                paddle_y <= '0;
            end
        end
    end

    // Paddle stays fully on screen
    assert property (@(posedge clk_pix) disable iff (reset)
        paddle_y <= y_max);

endmodule

`default_nettype wire

//--- source/ball_engine.sv
`timescale 1ns/1ns
`default_nettype none

module ball_engine
    import pong_pkg::*;
(
    input  wire logic clk_pix,
    input  wire logic reset,
    input  wire logic frame_tick,
    input  wire logic btn_c,
    input  coord_t    left_y,
    input  coord_t    right_y,
    output ball_t     ball,
    output game_state_e state,
    output logic      restart,
    output score_t    score_left,
    output score_t    score_right
);

    localparam int rally_w = $clog2(hits_per_step);

    localparam ball_t ball_home = '{
        x:         coord_t'(ball_x_home),
        y:         coord_t'(ball_y_home),
        dir_right: 1'b1,
        dir_down:  1'b0
    };

    speed_t             speed_x;
    speed_t             speed_y;
    logic [rally_w-1:0] rally_cnt;
    logic               btn_c_q;

    logic play_tick;
    logic hit_left, hit_right;
    logic miss_left, miss_right;
    logic left_wins, right_wins;
    logic serve;
    logic speed_up;

    // --------------------
    // Events for this tick
    // --------------------
    assign restart   = btn_c && !btn_c_q && (state == gs_over);
    assign play_tick = frame_tick && (state == gs_play);

    assign hit_right = ball.dir_right
        && (ball.x + ball_size >= paddle_x_right) && (ball.x <= paddle_x_right + paddle_w)
        && (ball.y + ball_size >= right_y) && (ball.y <= right_y + paddle_h);
    assign hit_left  = !ball.dir_right
        && (ball.x <= paddle_x_left + paddle_w) && (ball.x + ball_size >= paddle_x_left)
        && (ball.y + ball_size >= left_y) && (ball.y <= left_y + paddle_h);

    assign miss_right = play_tick && ball.dir_right && !hit_right
        && (ball.x >= h_visible - ball_size - speed_x);     // Left side scores
    assign miss_left  = play_tick && !ball.dir_right && !hit_left
        && (ball.x <= speed_x);                             // Right side scores

    assign left_wins  = miss_right && (score_left == score_t'(win_score - 1));
    assign right_wins = miss_left && (score_right == score_t'(win_score - 1));

    // Re-serve after a point unless the point ends the game
    assign serve    = restart || (miss_right && !left_wins) || (miss_left && !right_wins);
    assign speed_up = (rally_cnt == rally_w'(hits_per_step - 1));

    // --------------------
    // Ball and rally
    // --------------------
    always_ff @(posedge clk_pix) begin
        if (reset || serve) begin
            ball      <= ball_home;
            speed_x   <= speed_t'(speed_start);
            speed_y   <= speed_t'(speed_start);
            rally_cnt <= '0;
        end else if (play_tick) begin
            // Vertical motion with wall bounce
            if (ball.dir_down) begin
                if (ball.y >= v_visible - ball_size - speed_y) begin
                    ball.y        <= coord_t'(v_visible - ball_size);
                    ball.dir_down <= 1'b0;
                end else begin
                    ball.y <= ball.y + speed_y;
                end
            end else if (ball.y <= speed_y) begin
                ball.y        <= '0;
                ball.dir_down <= 1'b1;
            end else begin
                ball.y <= ball.y - speed_y;
            end

            if (hit_right || hit_left) begin
                ball.dir_right <= hit_left;
                ball.x <= hit_left ? coord_t'(paddle_x_left + paddle_w)
                                   : coord_t'(paddle_x_right - ball_size);
                rally_cnt <= speed_up ? '0 : rally_cnt + 1'b1;
                if (speed_up && speed_x < speed_max) speed_x <= speed_x + 1'b1;
                if (speed_up && speed_y < speed_max) speed_y <= speed_y + 1'b1;
            end else if (!miss_right && !miss_left) begin
                ball.x <= ball.dir_right ? ball.x + speed_x : ball.x - speed_x;
            end
        end
    end

    // --------------------
    // Scores and game state
    // --------------------
    always_ff @(posedge clk_pix) begin
        if (reset) begin
            btn_c_q     <= 1'b0;
            score_left  <= '0;
            score_right <= '0;
            state       <= gs_play;
        end else begin
            btn_c_q <= btn_c;
            if (restart) begin
                score_left  <= '0;
                score_right <= '0;
                state       <= gs_play;
            end else begin
                if (miss_right) score_left  <= score_left + 1'b1;
                if (miss_left)  score_right <= score_right + 1'b1;
                if (left_wins || right_wins) state <= gs_over;
            end
        end
    end

    assert property (@(posedge clk_pix) disable iff (reset)
        (score_left <= win_score) && (score_right <= win_score));

endmodule

`default_nettype wire

//--- source/pong_renderer.sv
`timescale 1ns/1ns
`default_nettype none

module pong_renderer
    import pong_pkg::*;
(
    input  wire logic  clk_pix,
    input  wire logic  reset,
    input  pixel_t     pix,
    input  ball_t      ball,
    input  coord_t     left_y,
    input  coord_t     right_y,
    input  game_state_e state,
    output rgb_t       rgb
);

    localparam rgb_t black = '{r: 4'h0, g: 4'h0, b: 4'h0};
    localparam rgb_t gray  = '{r: 4'h4, g: 4'h4, b: 4'h4};
    localparam rgb_t white = '{r: 4'hF, g: 4'hF, b: 4'hF};

    rgb_t colour;

    // True when (px, py) lies inside the w by h box at (x0, y0)
    function automatic logic in_box(input coord_t px, py, x0, y0, input int w, h);
        return (px >= x0) && (px < x0 + w) && (py >= y0) && (py < y0 + h);
    endfunction

    always_comb begin
        colour = black;
        if (pix.display_en && state == gs_play) begin
            if (pix.x == coord_t'(h_visible / 2) && !pix.y[4]) begin
                colour = gray;                              // Dashed centre line
            end
            if (in_box(pix.x, pix.y, coord_t'(paddle_x_left), left_y, paddle_w, paddle_h)
                || in_box(pix.x, pix.y, coord_t'(paddle_x_right), right_y, paddle_w, paddle_h)
                || in_box(pix.x, pix.y, ball.x, ball.y, ball_size, ball_size)) begin
                colour = white;
            end
        end
    end

    always_ff @(posedge clk_pix) begin
        if (reset) begin
            rgb <= black;
        end else begin
            rgb <= colour;
        end
    end

endmodule

`default_nettype wire

//--- source/pong_top.sv
`timescale 1ns/1ns
`default_nettype none

module pong_top
    import pong_pkg::*;
(
    input  wire logic clk_pix,
    input  wire logic reset,
    input  wire logic frame_tick,
    input  wire logic btn_u,
    input  wire logic btn_d,
    input  wire logic btn_c,
    input  pixel_t    pix,
    output rgb_t      rgb,
    output score_t    score_left,
    output score_t    score_right
);

    localparam int num_paddles = 2;     // Index 0 is the player, 1 the automatic side

    move_t  [num_paddles-1:0] move;
    coord_t [num_paddles-1:0] paddle_y;
    ball_t                    ball;
    game_state_e              state;
    logic                     restart;

    paddle_command #(
        .num_paddles (num_paddles)
    ) u_command (
        .frame_tick (frame_tick),
        .btn_u      (btn_u),
        .btn_d      (btn_d),
        .state      (state),
        .ball       (ball),
        .right_y    (paddle_y[1]),
        .move       (move)
    );

    for (genvar i = 0; i < num_paddles; i++) begin : g_paddle
        paddle_mover #(
            .step (i == 0 ? player_speed : auto_speed)
        ) u_mover (
            .clk_pix  (clk_pix),
            .reset    (reset),
            .restart  (restart),
            .move     (move[i]),
            .paddle_y (paddle_y[i])
        );
    end

    ball_engine u_ball (
        .clk_pix     (clk_pix),
        .reset       (reset),
        .frame_tick  (frame_tick),
        .btn_c       (btn_c),
        .left_y      (paddle_y[0]),
        .right_y     (paddle_y[1]),
        .ball        (ball),
        .state       (state),
        .restart     (restart),
        .score_left  (score_left),
        .score_right (score_right)
    );

    pong_renderer u_renderer (
        .clk_pix (clk_pix),
        .reset   (reset),
        .pix     (pix),
        .ball    (ball),
        .left_y  (paddle_y[0]),
        .right_y (paddle_y[1]),
        .state   (state),
        .rgb     (rgb)
    );

endmodule

`default_nettype wire

//--- sim/tb_pong.sv
`timescale 1ns/1ns
`default_nettype none

module tb_pong
    import pong_pkg::*;
();

    localparam rgb_t black = 12'h000;
    localparam rgb_t gray  = 12'h444;
    localparam rgb_t white = 12'hFFF;

    // Both full games stay well under 30000 frames of at most 6 cycles each,
    // the game-over screen probe adds about 19200 cycles
    localparam int max_frames       = 30000;
    localparam int cycles_per_frame = 6;
    localparam int probe_cycles     = 20000;
    localparam int timeout_cycles   = max_frames * cycles_per_frame + probe_cycles;

    logic   clk_pix;
    logic   reset;
    logic   frame_tick;
    logic   btn_u;
    logic   btn_d;
    logic   btn_c;
    pixel_t pix;
    rgb_t   rgb;
    score_t score_left;
    score_t score_right;
    int     cycle_count;

    pong_top u_dut (
        .clk_pix     (clk_pix),
        .reset       (reset),
        .frame_tick  (frame_tick),
        .btn_u       (btn_u),
        .btn_d       (btn_d),
        .btn_c       (btn_c),
        .pix         (pix),
        .rgb         (rgb),
        .score_left  (score_left),
        .score_right (score_right)
    );

    initial begin
        clk_pix = 1'b0;
        forever #10 clk_pix = ~clk_pix;     // 20 ns period
    end

    initial begin
        cycle_count = 0;
        while (cycle_count < timeout_cycles) begin
            @(posedge clk_pix);
            cycle_count++;
        end
        stop_with_error($sformatf("Timeout after %0d clock cycles", cycle_count));
    end

    // --------------------
    // Helpers
    // --------------------
    task automatic stop_with_error(input string reason);
        $display("%s", reason);
        $display("Test failed");
        $fatal(1);
    endtask

    // One frame_tick pulse, then 3 to 5 idle cycles
    task automatic run_frame();
        int idle;
        idle = 3 + int'($urandom % 3);
        frame_tick = 1'b1;
        @(negedge clk_pix);
        frame_tick = 1'b0;
        repeat (idle) @(negedge clk_pix);
    endtask

    task automatic probe_pixel(input int x, input int y, input logic en, input rgb_t exp);
        pix.x          = coord_t'(x);
        pix.y          = coord_t'(y);
        pix.display_en = en;
        @(negedge clk_pix);                 // Colour registered at the edge in between
        assert (rgb == exp) else stop_with_error($sformatf(
            "Mismatch at %0t ns: rgb at (%0d,%0d) expected %03h got %03h",
            $time, x, y, exp, rgb));
    endtask

    task automatic check_scores(input int exp_left, input int exp_right);
        assert (int'(score_left) == exp_left) else stop_with_error($sformatf(
            "Mismatch at %0t ns: score_left expected %0d got %0d",
            $time, exp_left, score_left));
        assert (int'(score_right) == exp_right) else stop_with_error($sformatf(
            "Mismatch at %0t ns: score_right expected %0d got %0d",
            $time, exp_right, score_right));
    endtask

    // Frames until one side wins, every score change must be a single point
    task automatic play_until_game_over(output int final_left, output int final_right);
        int prev_left;
        int prev_right;
        int points;
        prev_left  = 0;
        prev_right = 0;
        points     = 0;
        while (prev_left < win_score && prev_right < win_score) begin
            run_frame();
            if (int'(score_left) != prev_left || int'(score_right) != prev_right) begin
                assert ((int'(score_left) == prev_left + 1 && int'(score_right) == prev_right)
                    || (int'(score_right) == prev_right + 1 && int'(score_left) == prev_left))
                    else stop_with_error($sformatf(
                        "Mismatch at %0t ns: score_left:score_right went from %0d:%0d to %0d:%0d",
                        $time, prev_left, prev_right, score_left, score_right));
                prev_left  = int'(score_left);
                prev_right = int'(score_right);
                points++;
            end
        end
        $display("Game over after %0d points, %0d:%0d", points, prev_left, prev_right);
        final_left  = prev_left;
        final_right = prev_right;
    endtask

    // --------------------
    // Directed tests
    // --------------------
    task automatic check_reset_state();
        check_scores(0, 0);
        probe_pixel(320, 240, 1'b1, white);     // Ball at home
        probe_pixel(320, 0, 1'b1, gray);        // Centre line dash
        probe_pixel(320, 16, 1'b1, black);      // Gap in the dashes
        probe_pixel(320, 240, 1'b0, black);
        probe_pixel(100, 100, 1'b0, black);
    endtask

    task automatic follow_ball_flight();
        run_frame();
        probe_pixel(318, 234, 1'b1, white);
        probe_pixel(325, 241, 1'b1, white);
        probe_pixel(317, 237, 1'b1, black);
        probe_pixel(326, 237, 1'b1, black);
        // Ball reaches the top wall after 118 frames in all
        repeat (117) run_frame();
        probe_pixel(555, 3, 1'b1, white);
        probe_pixel(551, 3, 1'b1, black);
        run_frame();                            // Bounced, now moving down
        probe_pixel(555, 9, 1'b1, white);
        probe_pixel(555, 0, 1'b1, black);
        check_scores(0, 0);
    endtask

    task automatic move_player_paddle();
        btn_u = 1'b1;
        repeat (60) run_frame();
        btn_u = 1'b0;
        probe_pixel(35, 0, 1'b1, white);
        probe_pixel(35, 63, 1'b1, white);
        probe_pixel(35, 64, 1'b1, black);
        btn_d = 1'b1;
        repeat (5) run_frame();                 // 5 steps of 4 pixels
        btn_d = 1'b0;
        probe_pixel(35, 19, 1'b1, black);
        probe_pixel(35, 20, 1'b1, white);
        probe_pixel(35, 83, 1'b1, white);
        probe_pixel(35, 84, 1'b1, black);
        check_scores(0, 0);
    endtask

    task automatic play_full_game();
        int final_left;
        int final_right;
        play_until_game_over(final_left, final_right);
        // Whole visible area on a 4 pixel grid
        for (int y = 0; y < v_visible; y += 4) begin
            for (int x = 0; x < h_visible; x += 4) begin
                probe_pixel(x, y, 1'b1, black);
            end
        end
    endtask

    task automatic restart_after_game_over();
        int saved_left;
        int saved_right;
        int final_left;
        int final_right;
        saved_left  = int'(score_left);
        saved_right = int'(score_right);
        repeat (20) run_frame();
        check_scores(saved_left, saved_right);
        btn_c = 1'b1;
        @(negedge clk_pix);                     // Rising edge seen, cleared at this edge
        check_scores(0, 0);
        probe_pixel(320, 240, 1'b1, white);
        // Button still held, the game must keep running
        repeat (10) run_frame();
        check_scores(0, 0);
        probe_pixel(336, 216, 1'b1, white);
        probe_pixel(343, 223, 1'b1, white);
        probe_pixel(320, 240, 1'b1, black);     // Ball left home
        // Second game ends with the button still held, no new restart
        play_until_game_over(final_left, final_right);
        repeat (20) run_frame();
        check_scores(final_left, final_right);
        btn_c = 1'b0;
    endtask

    initial begin
        reset      = 1'b1;
        frame_tick = 1'b0;
        btn_u      = 1'b0;
        btn_d      = 1'b0;
        btn_c      = 1'b0;
        pix        = '0;
        void'($urandom(32'h3439c5dc));
        repeat (3) @(posedge clk_pix);
        @(negedge clk_pix);
        reset = 1'b0;

        check_reset_state();
        follow_ball_flight();
        move_player_paddle();
        play_full_game();
        restart_after_game_over();

        $display("Test passed");
        $finish;
    end

endmodule

`default_nettype wire

//--- tb.f
source/pong_pkg.sv
source/paddle_command.sv
source/paddle_mover.sv
source/ball_engine.sv
source/pong_renderer.sv
source/pong_top.sv
sim/tb_pong.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the pong testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f tb.f --top-module tb_pong -o tb_pong_sim
./obj_dir/tb_pong_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "Test failed" sim.log; then
    exit 1
fi
grep -q "Test passed" sim.log
